// File: verilog/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'h1c000000

`define CORE_XLEN 32
`define CORE_NREG 32

// opcode match values, LoongArch32 encodings
// add.w matches inst[31:15]
`define CORE_OP_ADD_W   17'h00020
// addi.w, ld.w and st.w match inst[31:22]
`define CORE_OP_ADDI_W  10'h00a
`define CORE_OP_LD_W    10'h0a2
`define CORE_OP_ST_W    10'h0a6
// lu12i.w matches inst[31:25]
`define CORE_OP_LU12I_W 7'h0a
// beq matches inst[31:26]
`define CORE_OP_BEQ     6'h16

`endif

// File: verilog/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [4:0]            reg_idx_t;

    typedef enum logic [0:0] {
        ALU_ADD,
        ALU_LUI
    } alu_op_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fs_ds_t;

    typedef struct packed {
        word_t    pc;
        word_t    src1;
        word_t    src2;
        word_t    st_data;
        reg_idx_t dest;
        alu_op_t  alu_op;
        logic     mem_rd;
        logic     mem_wr;
        logic     rf_we;
    } ds_es_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        reg_idx_t dest;
        logic     mem_rd;
        logic     rf_we;
    } es_ms_t;

    typedef struct packed {
        word_t    pc;
        word_t    wdata;
        reg_idx_t dest;
        logic     rf_we;
    } ms_ws_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_t;

    typedef struct packed {
        logic     we;
        reg_idx_t addr;
        word_t    data;
    } rf_wr_t;

    // pending register write seen by the decode hazard check
    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
    } fwd_t;

endpackage

// File: verilog/if_stage.sv
`include "core_defines.svh"

module if_stage import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ds_allowin,
    input  br_t        br_bus,
    output logic       fs_to_ds_valid,
    output fs_ds_t     fs_to_ds_bus,
    output logic       inst_sram_en,
    output logic [3:0] inst_sram_we,
    output word_t      inst_sram_addr,
    output word_t      inst_sram_wdata,
    input  word_t      inst_sram_rdata
);

    logic  pre_valid;
    logic  fs_valid;
    logic  fs_ready_go;
    logic  fs_allowin;
    word_t fs_pc;
    word_t seq_pc;
    word_t next_pc;
    logic  inst_buf_valid;
    word_t inst_buf;

    // fetch requests start one cycle after reset is released
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_valid <= 1'b0;
        end else begin
            pre_valid <= 1'b1;
        end
    end

    assign seq_pc  = fs_pc + word_t'(4);
    assign next_pc = br_bus.taken ? br_bus.target : seq_pc;

    assign fs_ready_go    = 1'b1;
    assign fs_allowin     = !fs_valid || (fs_ready_go && ds_allowin);
    // instruction behind a taken beq is squashed
    assign fs_to_ds_valid = fs_valid && fs_ready_go && !br_bus.taken;

    assign inst_sram_en    = pre_valid && fs_allowin;
    assign inst_sram_we    = 4'h0;
    assign inst_sram_addr  = next_pc;
    assign inst_sram_wdata = '0;

    // fs_pc starts one word early so the first request is the reset pc
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fs_valid <= 1'b0;
            fs_pc    <= `CORE_RESET_PC - word_t'(4);
        end else begin
            if (fs_allowin) begin
                fs_valid <= pre_valid;
            end
            if (inst_sram_en) begin
                fs_pc <= next_pc;
            end
        end
    end

    // sram data is only there for one cycle, keep it while decode stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_buf_valid <= 1'b0;
        end else if (fs_allowin) begin
            inst_buf_valid <= 1'b0;
        end else if (!inst_buf_valid) begin
            inst_buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!fs_allowin && !inst_buf_valid) begin
            inst_buf <= inst_sram_rdata;
        end
    end

    assign fs_to_ds_bus.pc   = fs_pc;
    assign fs_to_ds_bus.inst = inst_buf_valid ? inst_buf : inst_sram_rdata;

endmodule

// File: verilog/id_stage.sv
`include "core_defines.svh"

module id_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fs_to_ds_valid,
    input  fs_ds_t   fs_to_ds_bus,
    input  logic     es_allowin,
    input  fwd_t     es_fwd,
    input  fwd_t     ms_fwd,
    input  rf_wr_t   rf_wr,
    input  word_t    rf_rdata1,
    input  word_t    rf_rdata2,
    output logic     ds_allowin,
    output logic     ds_to_es_valid,
    output ds_es_t   ds_to_es_bus,
    output br_t      br_bus,
    output reg_idx_t rf_raddr1,
    output reg_idx_t rf_raddr2
);

    logic     ds_valid;
    logic     ds_ready_go;
    fs_ds_t   ds_r;
    word_t    inst;
    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    logic     is_add;
    logic     is_addi;
    logic     is_lu12i;
    logic     is_ld;
    logic     is_st;
    logic     is_beq;
    logic     use_r1;
    logic     use_r2;
    word_t    imm12;
    word_t    imm20;
    word_t    br_offs;
    logic     hazard;

    // true when r is still owed a write by a later stage
    function automatic logic pending(input reg_idx_t r, input fwd_t es, input fwd_t ms,
                                     input rf_wr_t wb);
        logic hit;
        hit = (es.valid && es.dest == r) || (ms.valid && ms.dest == r) ||
              (wb.we && wb.addr == r);
        return (r != '0) && hit;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_r <= fs_to_ds_bus;
        end
    end

    assign inst = ds_r.inst;
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];

    assign is_add   = inst[31:15] == `CORE_OP_ADD_W;
    assign is_addi  = inst[31:22] == `CORE_OP_ADDI_W;
    assign is_lu12i = inst[31:25] == `CORE_OP_LU12I_W;
    assign is_ld    = inst[31:22] == `CORE_OP_LD_W;
    assign is_st    = inst[31:22] == `CORE_OP_ST_W;
    assign is_beq   = inst[31:26] == `CORE_OP_BEQ;

    assign imm12   = {{20{inst[21]}}, inst[21:10]};
    assign imm20   = {inst[24:5], 12'b0};
    assign br_offs = {{14{inst[25]}}, inst[25:10], 2'b00};

    // st.w and beq read rd as their second operand
    assign rf_raddr1 = rj;
    assign rf_raddr2 = (is_st || is_beq) ? rd : rk;

    assign use_r1 = is_add || is_addi || is_ld || is_st || is_beq;
    assign use_r2 = is_add || is_st || is_beq;

    assign hazard = (use_r1 && pending(rf_raddr1, es_fwd, ms_fwd, rf_wr)) ||
                    (use_r2 && pending(rf_raddr2, es_fwd, ms_fwd, rf_wr));

    assign ds_ready_go    = !hazard;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    // redirect only when the beq actually leaves decode
    assign br_bus.taken  = ds_valid && ds_ready_go && es_allowin && is_beq &&
                           (rf_rdata1 == rf_rdata2);
    assign br_bus.target = ds_r.pc + br_offs;

    assign ds_to_es_bus.pc      = ds_r.pc;
    assign ds_to_es_bus.src1    = rf_rdata1;
    assign ds_to_es_bus.src2    = is_add ? rf_rdata2 : (is_lu12i ? imm20 : imm12);
    assign ds_to_es_bus.st_data = rf_rdata2;
    assign ds_to_es_bus.dest    = rd;
    assign ds_to_es_bus.alu_op  = is_lu12i ? ALU_LUI : ALU_ADD;
    assign ds_to_es_bus.mem_rd  = is_ld;
    assign ds_to_es_bus.mem_wr  = is_st;
    assign ds_to_es_bus.rf_we   = is_add || is_addi || is_lu12i || is_ld;

endmodule

// File: verilog/regfile.sv
`include "core_defines.svh"

module regfile import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  rf_wr_t   wr,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [`CORE_NREG];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: verilog/exe_stage.sv
module exe_stage import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ds_to_es_valid,
    input  ds_es_t     ds_to_es_bus,
    input  logic       ms_allowin,
    output logic       es_allowin,
    output logic       es_to_ms_valid,
    output es_ms_t     es_to_ms_bus,
    output fwd_t       es_fwd,
    output logic       data_sram_en,
    output logic [3:0] data_sram_we,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata
);

    logic   es_valid;
    logic   es_ready_go;
    logic   es_go;
    ds_es_t es_r;
    word_t  alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_r <= ds_to_es_bus;
        end
    end

    assign es_ready_go    = 1'b1;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;
    assign es_go          = es_to_ms_valid && ms_allowin;

    // lu12i.w carries its shifted immediate in src2
    assign alu_result = (es_r.alu_op == ALU_LUI) ? es_r.src2 : es_r.src1 + es_r.src2;

    // sram access fires in the cycle the instruction moves into mem
    assign data_sram_en    = es_go && (es_r.mem_rd || es_r.mem_wr);
    assign data_sram_we    = (es_go && es_r.mem_wr) ? 4'hf : 4'h0;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = es_r.st_data;

    assign es_to_ms_bus.pc     = es_r.pc;
    assign es_to_ms_bus.result = alu_result;
    assign es_to_ms_bus.dest   = es_r.dest;
    assign es_to_ms_bus.mem_rd = es_r.mem_rd;
    assign es_to_ms_bus.rf_we  = es_r.rf_we;

    assign es_fwd.valid = es_valid && es_r.rf_we;
    assign es_fwd.dest  = es_r.dest;

endmodule

// File: verilog/mem_stage.sv
module mem_stage import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   es_to_ms_valid,
    input  es_ms_t es_to_ms_bus,
    input  logic   ws_allowin,
    input  word_t  data_sram_rdata,
    output logic   ms_allowin,
    output logic   ms_to_ws_valid,
    output ms_ws_t ms_to_ws_bus,
    output fwd_t   ms_fwd
);

    logic   ms_valid;
    logic   ms_ready_go;
    es_ms_t ms_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_r <= es_to_ms_bus;
        end
    end

    assign ms_ready_go    = 1'b1;
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    // load data returns in the first mem cycle
    assign ms_to_ws_bus.pc    = ms_r.pc;
    assign ms_to_ws_bus.wdata = ms_r.mem_rd ? data_sram_rdata : ms_r.result;
    assign ms_to_ws_bus.dest  = ms_r.dest;
    assign ms_to_ws_bus.rf_we = ms_r.rf_we;

    assign ms_fwd.valid = ms_valid && ms_r.rf_we;
    assign ms_fwd.dest  = ms_r.dest;

endmodule

// File: verilog/wb_stage.sv
module wb_stage import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ms_to_ws_valid,
    input  ms_ws_t     ms_to_ws_bus,
    output logic       ws_allowin,
    output rf_wr_t     rf_wr,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic   ws_valid;
    logic   ws_ready_go;
    ms_ws_t ws_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_r <= ms_to_ws_bus;
        end
    end

    // last stage, retires every cycle
    assign ws_ready_go = 1'b1;
    assign ws_allowin  = !ws_valid || ws_ready_go;

    assign rf_wr.we   = ws_valid && ws_r.rf_we;
    assign rf_wr.addr = ws_r.dest;
    assign rf_wr.data = ws_r.wdata;

    assign debug_wb_pc       = ws_r.pc;
    assign debug_wb_rf_we    = {4{rf_wr.we}};
    assign debug_wb_rf_wnum  = ws_r.dest;
    assign debug_wb_rf_wdata = ws_r.wdata;

endmodule

// File: verilog/mycpu_top.sv
module mycpu_top import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // instruction sram
    output logic       inst_sram_en,
    output logic [3:0] inst_sram_we,
    output word_t      inst_sram_addr,
    output word_t      inst_sram_wdata,
    input  word_t      inst_sram_rdata,
    // data sram
    output logic       data_sram_en,
    output logic [3:0] data_sram_we,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  word_t      data_sram_rdata,
    // retire trace
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic     ds_allowin;
    logic     es_allowin;
    logic     ms_allowin;
    logic     ws_allowin;
    logic     fs_to_ds_valid;
    logic     ds_to_es_valid;
    logic     es_to_ms_valid;
    logic     ms_to_ws_valid;
    fs_ds_t   fs_to_ds_bus;
    ds_es_t   ds_to_es_bus;
    es_ms_t   es_to_ms_bus;
    ms_ws_t   ms_to_ws_bus;
    br_t      br_bus;
    fwd_t     es_fwd;
    fwd_t     ms_fwd;
    rf_wr_t   rf_wr;
    reg_idx_t rf_raddr1;
    reg_idx_t rf_raddr2;
    word_t    rf_rdata1;
    word_t    rf_rdata2;

    if_stage if_stage_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .ds_allowin      (ds_allowin),
        .br_bus          (br_bus),
        .fs_to_ds_valid  (fs_to_ds_valid),
        .fs_to_ds_bus    (fs_to_ds_bus),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_we    (inst_sram_we),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_wdata (inst_sram_wdata),
        .inst_sram_rdata (inst_sram_rdata)
    );

    id_stage id_stage_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .rf_wr          (rf_wr),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_bus         (br_bus),
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2)
    );

    // register file sits beside decode
    regfile regfile_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .wr     (rf_wr),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    exe_stage exe_stage_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .ds_to_es_valid  (ds_to_es_valid),
        .ds_to_es_bus    (ds_to_es_bus),
        .ms_allowin      (ms_allowin),
        .es_allowin      (es_allowin),
        .es_to_ms_valid  (es_to_ms_valid),
        .es_to_ms_bus    (es_to_ms_bus),
        .es_fwd          (es_fwd),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    mem_stage mem_stage_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .es_to_ms_valid  (es_to_ms_valid),
        .es_to_ms_bus    (es_to_ms_bus),
        .ws_allowin      (ws_allowin),
        .data_sram_rdata (data_sram_rdata),
        .ms_allowin      (ms_allowin),
        .ms_to_ws_valid  (ms_to_ws_valid),
        .ms_to_ws_bus    (ms_to_ws_bus),
        .ms_fwd          (ms_fwd)
    );

    wb_stage wb_stage_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .ms_to_ws_valid    (ms_to_ws_valid),
        .ms_to_ws_bus      (ms_to_ws_bus),
        .ws_allowin        (ws_allowin),
        .rf_wr             (rf_wr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

// File: testbench/tb_top.sv
`include "core_defines.svh"

module tb_top import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FETCH_TIMEOUT = 20;
    localparam int TRACE_TIMEOUT = 200;
    localparam int QUIET_CYCLES  = 20;
    localparam int MODEL_STEPS   = 2000;

    typedef struct packed {
        word_t    pc;
        reg_idx_t wnum;
        word_t    wdata;
    } trace_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic       inst_sram_en;
    logic [3:0] inst_sram_we;
    word_t      inst_sram_addr;
    word_t      inst_sram_wdata;
    word_t      inst_sram_rdata;
    logic       data_sram_en;
    logic [3:0] data_sram_we;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t  imem [word_t];
    word_t  dmem [word_t];
    word_t  model_mem [word_t];
    word_t  prog [$];
    trace_t exp_trace [$];
    store_t exp_st [$];
    store_t st_seen [$];

    // pending sram requests answered after the next rising edge
    logic  i_req;
    logic  d_req;
    word_t i_addr;
    word_t d_addr;

    mycpu_top dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #4 clk = ~clk;

    // LoongArch32 encoders
    function automatic word_t add_w(input reg_idx_t rd, input reg_idx_t rj, input reg_idx_t rk);
        return {`CORE_OP_ADD_W, rk, rj, rd};
    endfunction

    function automatic word_t addi_w(input reg_idx_t rd, input reg_idx_t rj,
                                     input logic [11:0] si12);
        return {`CORE_OP_ADDI_W, si12, rj, rd};
    endfunction

    function automatic word_t lu12i_w(input reg_idx_t rd, input logic [19:0] si20);
        return {`CORE_OP_LU12I_W, si20, rd};
    endfunction

    function automatic word_t ld_w(input reg_idx_t rd, input reg_idx_t rj,
                                   input logic [11:0] si12);
        return {`CORE_OP_LD_W, si12, rj, rd};
    endfunction

    // rd holds the store data
    function automatic word_t st_w(input reg_idx_t rd, input reg_idx_t rj,
                                   input logic [11:0] si12);
        return {`CORE_OP_ST_W, si12, rj, rd};
    endfunction

    // offset counts instructions
    function automatic word_t beq(input reg_idx_t rj, input reg_idx_t rd,
                                  input logic [15:0] offs);
        return {`CORE_OP_BEQ, offs, rj, rd};
    endfunction

    // unmapped words decode as none of the six instructions
    function automatic word_t read_imem(input word_t addr);
        return imem.exists(addr) ? imem[addr] : {6'h3f, addr[25:0] ^ addr[31:6]};
    endfunction

    function automatic word_t data_fill(input word_t addr);
        return addr ^ 32'h3c3c_c3c3;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // sram models sample requests mid-cycle
    always begin
        @(negedge clk);
        if (rst_n === 1'b1) begin
            i_req  = inst_sram_en;
            i_addr = inst_sram_addr;
            d_req  = data_sram_en && (data_sram_we == 4'h0);
            d_addr = data_sram_addr;
            compare_value("inst_sram_we", word_t'(inst_sram_we), '0);
            compare_value("inst_sram_wdata", inst_sram_wdata, '0);
            if (data_sram_en && data_sram_we != 4'h0) begin
                compare_value("data_sram_we", word_t'(data_sram_we), 32'hf);
                dmem[data_sram_addr] = data_sram_wdata;
                st_seen.push_back(store_t'{data_sram_addr, data_sram_wdata});
            end else if (!data_sram_en) begin
                compare_value("data_sram_we", word_t'(data_sram_we), '0);
            end
        end else begin
            i_req = 1'b0;
            d_req = 1'b0;
        end
        @(posedge clk);
        #1;
        if (i_req) begin
            inst_sram_rdata = read_imem(i_addr);
        end
        if (d_req) begin
            data_sram_rdata = dmem.exists(d_addr) ? dmem[d_addr] : data_fill(d_addr);
        end
    end

    // ISA level walk of prog that stops at the beq-to-self end marker
    task automatic run_model;
        word_t    regs [32];
        word_t    pc;
        word_t    off;
        word_t    inst;
        word_t    res;
        word_t    addr;
        word_t    sext12;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        logic     we;
        logic     done;
        int       steps;
        exp_trace.delete();
        exp_st.delete();
        model_mem.delete();
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc    = `CORE_RESET_PC;
        done  = 1'b0;
        steps = 0;
        while (!done) begin
            off = pc - `CORE_RESET_PC;
            if (steps == MODEL_STEPS || off >= word_t'(4 * prog.size())) begin
                stop_run("reference model ran off the end of the program");
            end
            inst   = prog[off >> 2];
            rd     = inst[4:0];
            rj     = inst[9:5];
            rk     = inst[14:10];
            sext12 = {{20{inst[21]}}, inst[21:10]};
            we     = 1'b1;
            res    = '0;
            if (inst[31:15] == `CORE_OP_ADD_W) begin
                res = regs[rj] + regs[rk];
            end else if (inst[31:22] == `CORE_OP_ADDI_W) begin
                res = regs[rj] + sext12;
            end else if (inst[31:25] == `CORE_OP_LU12I_W) begin
                res = {inst[24:5], 12'h000};
            end else if (inst[31:22] == `CORE_OP_LD_W) begin
                addr = regs[rj] + sext12;
                res  = model_mem.exists(addr) ? model_mem[addr] : data_fill(addr);
            end else if (inst[31:22] == `CORE_OP_ST_W) begin
                addr            = regs[rj] + sext12;
                model_mem[addr] = regs[rd];
                exp_st.push_back(store_t'{addr, regs[rd]});
                we              = 1'b0;
            end else if (inst[31:26] == `CORE_OP_BEQ) begin
                we = 1'b0;
                if (regs[rj] == regs[rd]) begin
                    done = (inst[25:10] == 16'h0);
                    pc   = pc + {{14{inst[25]}}, inst[25:10], 2'b00} - 32'h4;
                end
            end else begin
                stop_run("reference model found an instruction it cannot decode");
            end
            if (we) begin
                exp_trace.push_back(trace_t'{pc, rd, res});
                if (rd != '0) begin
                    regs[rd] = res;
                end
            end
            pc    = pc + 32'h4;
            steps = steps + 1;
        end
    endtask

    task automatic check_reset_outputs;
        compare_value("debug_wb_rf_we", word_t'(debug_wb_rf_we), '0);
        compare_value("data_sram_en", word_t'(data_sram_en), '0);
        compare_value("data_sram_we", word_t'(data_sram_we), '0);
    endtask

    task automatic wait_for_write(input string name);
        int n;
        for (n = 0; n < TRACE_TIMEOUT; n++) begin
            @(negedge clk);
            if (debug_wb_rf_we != 4'h0) begin
                break;
            end
        end
        if (n == TRACE_TIMEOUT) begin
            stop_run($sformatf("%s: no register write reached the trace within %0d cycles",
                               name, TRACE_TIMEOUT));
        end
        compare_value("debug_wb_rf_we", word_t'(debug_wb_rf_we), 32'hf);
    endtask

    // reset, run prog and compare the trace and stores with the model
    task automatic run_program(input string name);
        int n;
        prog.push_back(beq(0, 0, 16'h0000));
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        imem.delete();
        dmem.delete();
        st_seen.delete();
        foreach (prog[i]) begin
            imem[`CORE_RESET_PC + word_t'(4 * i)] = prog[i];
        end
        run_model();
        for (n = 0; n < 10; n++) begin
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (n = 0; n < FETCH_TIMEOUT; n++) begin
            @(negedge clk);
            check_reset_outputs();
            if (inst_sram_en) begin
                break;
            end
        end
        if (n == FETCH_TIMEOUT) begin
            stop_run($sformatf("%s: no instruction fetch after reset", name));
        end
        compare_value("inst_sram_addr", inst_sram_addr, `CORE_RESET_PC);
        foreach (exp_trace[i]) begin
            wait_for_write(name);
            compare_value("debug_wb_pc", debug_wb_pc, exp_trace[i].pc);
            compare_value("debug_wb_rf_wnum", word_t'(debug_wb_rf_wnum),
                          word_t'(exp_trace[i].wnum));
            compare_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_trace[i].wdata);
        end
        // program now spins on its end marker
        for (n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk);
            if (debug_wb_rf_we != 4'h0) begin
                stop_run($sformatf("%s: extra register write after the last expected one",
                                   name));
            end
        end
        compare_value("data_sram store count", word_t'(st_seen.size()),
                      word_t'(exp_st.size()));
        foreach (exp_st[i]) begin
            compare_value("data_sram_addr", st_seen[i].addr, exp_st[i].addr);
            compare_value("data_sram_wdata", st_seen[i].data, exp_st[i].data);
        end
        $display("%s: %0d writes and %0d stores matched", name, exp_trace.size(),
                 exp_st.size());
    endtask

    task automatic alu_chain;
        prog.delete();
        prog.push_back(lu12i_w(1, 20'h12345));
        prog.push_back(addi_w(1, 1, 12'h678));
        prog.push_back(addi_w(2, 1, 12'hfff));
        prog.push_back(add_w(3, 1, 2));
        prog.push_back(add_w(3, 3, 3));
        prog.push_back(addi_w(4, 0, 12'h7ff));
        prog.push_back(add_w(5, 4, 3));
        prog.push_back(lu12i_w(6, 20'hfffff));
        prog.push_back(add_w(7, 6, 5));
        run_program("alu chain");
    endtask

    task automatic load_store;
        prog.delete();
        prog.push_back(lu12i_w(1, 20'h00010));
        prog.push_back(lu12i_w(3, 20'hcafe0));
        prog.push_back(addi_w(3, 3, 12'h123));
        prog.push_back(addi_w(2, 0, 12'h5a5));
        prog.push_back(st_w(3, 1, 12'h008));
        prog.push_back(ld_w(4, 1, 12'h008));
        prog.push_back(add_w(5, 4, 2));
        prog.push_back(st_w(5, 1, 12'hffc));
        prog.push_back(ld_w(6, 1, 12'hffc));
        prog.push_back(addi_w(7, 6, 12'h001));
        prog.push_back(ld_w(8, 1, 12'h008));
        run_program("load store");
    endtask

    task automatic branch_paths;
        prog.delete();
        prog.push_back(addi_w(1, 0, 12'h005));
        prog.push_back(addi_w(2, 0, 12'h005));
        prog.push_back(addi_w(3, 0, 12'h007));
        // not taken while r3 is still in flight
        prog.push_back(beq(1, 3, 16'h0003));
        prog.push_back(addi_w(4, 0, 12'h001));
        prog.push_back(beq(1, 2, 16'h0003));
        prog.push_back(addi_w(5, 0, 12'h011));
        prog.push_back(addi_w(6, 0, 12'h022));
        prog.push_back(addi_w(7, 0, 12'h033));
        prog.push_back(beq(7, 7, 16'h0002));
        prog.push_back(addi_w(8, 0, 12'h044));
        prog.push_back(addi_w(9, 7, 12'h001));
        run_program("branches");
    endtask

    task automatic random_ops;
        reg_idx_t    rd;
        reg_idx_t    rj;
        reg_idx_t    rk;
        logic [11:0] imm;
        prog.delete();
        // nonzero write to r0 here, read back at the very end
        prog.push_back(addi_w(0, 0, 12'h5a5));
        // small register set keeps the hazards frequent
        for (int i = 0; i < 40; i++) begin
            rd  = reg_idx_t'($urandom_range(15, 1));
            rj  = reg_idx_t'($urandom_range(15, 0));
            rk  = reg_idx_t'($urandom_range(15, 0));
            imm = 12'($urandom());
            if ($urandom_range(1, 0) == 1) begin
                prog.push_back(add_w(rd, rj, rk));
            end else begin
                prog.push_back(addi_w(rd, rj, imm));
            end
        end
        prog.push_back(add_w(1, 0, 0));
        run_program("random ops");
    endtask

    initial begin
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        i_req           = 1'b0;
        d_req           = 1'b0;
        void'($urandom(54715));
        alu_chain();
        load_store();
        branch_paths();
        random_ops();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/core_pkg.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/regfile.sv
verilog/exe_stage.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/mycpu_top.sv
testbench/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build the pipeline testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_top -f all.f --Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_top_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
